/* verilog/soc_pkg.sv */
package soc_pkg;

    localparam int XLEN      = 32;
    localparam int ADDR_W    = 32;
    localparam int MEM_IDX_W = 20;                       // Word index field of an address.

    typedef logic [XLEN-1:0] uint_x;
    typedef logic [63:0]     uint64;

    typedef enum logic [3:0] {
        MTIME_LO    = 4'd0,
        MTIME_HI    = 4'd1,
        MTIMECMP_LO = 4'd2,
        MTIMECMP_HI = 4'd3,
        CYCLE_LO    = 4'd4,
        CYCLE_HI    = 4'd5,
        GP          = 4'd6,
        EXIT        = 4'd7
    } mmio_reg_e;

    // One address word, seen either as a memory word or as an MMIO register.
    typedef union packed {
        struct packed {
            logic                        is_mmio;
            logic [ADDR_W-MEM_IDX_W-4:0] unused;
            logic [MEM_IDX_W-1:0]        word_idx;
            logic [1:0]                  byte_off;
        } mem;
        struct packed {
            logic              is_mmio;
            logic [ADDR_W-8:0] unused;
            mmio_reg_e         reg_idx;                  // Bits 5..2.
            logic [1:0]        byte_off;
        } mmio;
    } bus_addr_u;

endpackage

/* verilog/mem_bus_if.sv */
interface mem_bus_if;
    import soc_pkg::*;

    logic  req_valid;
    logic  req_ready;
    uint_x req_addr;
    logic  req_wen;
    uint_x req_wdata;
    logic  resp_valid;
    uint_x resp_rdata;                                   // Zero on write responses.

    modport requester (
        output req_valid,
        output req_addr,
        output req_wen,
        output req_wdata,
        input  req_ready,
        input  resp_valid,
        input  resp_rdata
    );

    modport responder (
        input  req_valid,
        input  req_addr,
        input  req_wen,
        input  req_wdata,
        output req_ready,
        output resp_valid,
        output resp_rdata
    );

endinterface

/* verilog/soc_timer.sv */
module soc_timer #(
    parameter int FMAX_MHz = 27
) (
    input  logic           clk_in,
    input  logic           reset,
    output soc_pkg::uint64 mtime,
    output soc_pkg::uint64 cycle
);

    localparam int PRESC_W = (FMAX_MHz > 1) ? $clog2(FMAX_MHz) : 1;
    localparam logic [PRESC_W-1:0] PRESC_MAX = PRESC_W'(FMAX_MHz - 1);

    logic [PRESC_W-1:0] presc;
    logic               tick_us;

    assign tick_us = (presc == PRESC_MAX);               // One microsecond elapsed.

    always_ff @(posedge clk_in) begin
        if (reset) begin
            presc <= '0;
            cycle <= '0;
            mtime <= '0;
        end else begin
            cycle <= cycle + 64'd1;
            if (tick_us) begin
                presc <= '0;
                mtime <= mtime + 64'd1;
            end else begin
                presc <= presc + 1'b1;
            end
        end
    end

endmodule

/* verilog/mmio_cntr.sv */
module mmio_cntr (
    input  logic           clk_in,
    input  logic           reset,
    mem_bus_if.responder   core,
    mem_bus_if.requester   mem,
    input  soc_pkg::uint64 mtime,
    input  soc_pkg::uint64 cycle,
    output logic [5:0]     led,
    output logic           exit,
    output logic           timer_irq
);
    import soc_pkg::*;

    bus_addr_u addr_u;
    logic      is_mmio;
    logic      mmio_xfer;
    logic      mem_xfer;
    logic      mem_pending;
    logic      mmio_resp_valid;
    uint_x     mmio_rdata;
    uint_x     reg_rdata;
    uint_x     gp;
    uint64     mtimecmp;

    assign addr_u  = core.req_addr;
    assign is_mmio = addr_u.mem.is_mmio;

    // Memory accesses go out untouched.
    assign mem.req_valid = core.req_valid && !is_mmio;
    assign mem.req_addr  = core.req_addr;
    assign mem.req_wen   = core.req_wen;
    assign mem.req_wdata = core.req_wdata;

    assign core.req_ready = is_mmio ? !mem_pending : mem.req_ready;

    assign mmio_xfer = core.req_valid && core.req_ready && is_mmio;
    assign mem_xfer  = mem.req_valid && mem.req_ready;

    assign core.resp_valid = mmio_resp_valid || mem.resp_valid;
    assign core.resp_rdata = mmio_resp_valid ? mmio_rdata : mem.resp_rdata;

    assign led = ~gp[5:0];                               // LEDs are active low.

    always_comb begin
        case (addr_u.mmio.reg_idx)
            MTIME_LO:    reg_rdata = mtime[31:0];
            MTIME_HI:    reg_rdata = mtime[63:32];
            MTIMECMP_LO: reg_rdata = mtimecmp[31:0];
            MTIMECMP_HI: reg_rdata = mtimecmp[63:32];
            CYCLE_LO:    reg_rdata = cycle[31:0];
            CYCLE_HI:    reg_rdata = cycle[63:32];
            GP:          reg_rdata = gp;
            EXIT:        reg_rdata = uint_x'(exit);
            default:     reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            mmio_resp_valid <= 1'b0;
            mem_pending     <= 1'b0;
            mtimecmp        <= '1;
            gp              <= '0;
            exit            <= 1'b0;
            timer_irq       <= 1'b0;
        end else begin
            mmio_resp_valid <= mmio_xfer;
            timer_irq       <= (mtime >= mtimecmp);
            if (mem_xfer) begin
                mem_pending <= 1'b1;
            end else if (mem.resp_valid) begin
                mem_pending <= 1'b0;
            end
            if (mmio_xfer && core.req_wen) begin
                case (addr_u.mmio.reg_idx)
                    MTIMECMP_LO: mtimecmp[31:0]  <= core.req_wdata;
                    MTIMECMP_HI: mtimecmp[63:32] <= core.req_wdata;
                    GP:          gp              <= core.req_wdata;
                    EXIT:        exit            <= 1'b1;  // Sticky until reset.
                    default:     ;                         // Counters are read only.
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (mmio_xfer) begin
            mmio_rdata <= core.req_wen ? '0 : reg_rdata;
        end
    end

    // Local and forwarded answers share one response channel.
    a_resp_exclusive: assert property (@(posedge clk_in) disable iff (reset)
        !(mmio_resp_valid && mem.resp_valid));

endmodule

/* verilog/mem_bus_arbiter.sv */
module mem_bus_arbiter (
    input  logic         clk_in,
    input  logic         reset,
    mem_bus_if.responder ibus,
    mem_bus_if.responder dbus,
    mem_bus_if.requester mem
);

    logic busy;
    logic owner_d;
    logic last_d;
    logic grant_i;
    logic grant_d;
    logic xfer;

    // Loser of the previous contest wins a tie.
    always_comb begin
        grant_i = 1'b0;
        grant_d = 1'b0;
        if (!busy) begin
            if (ibus.req_valid && dbus.req_valid) begin
                grant_d = !last_d;
                grant_i = last_d;
            end else begin
                grant_i = ibus.req_valid;
                grant_d = dbus.req_valid;
            end
        end
    end

    assign mem.req_valid = grant_i || grant_d;
    assign mem.req_addr  = grant_d ? dbus.req_addr  : ibus.req_addr;
    assign mem.req_wen   = grant_d ? dbus.req_wen   : ibus.req_wen;
    assign mem.req_wdata = grant_d ? dbus.req_wdata : ibus.req_wdata;

    assign ibus.req_ready = grant_i && mem.req_ready;
    assign dbus.req_ready = grant_d && mem.req_ready;

    assign xfer = mem.req_valid && mem.req_ready;

    // Response goes back to whoever owns the outstanding request.
    assign ibus.resp_valid = mem.resp_valid && !owner_d;
    assign dbus.resp_valid = mem.resp_valid && owner_d;
    assign ibus.resp_rdata = mem.resp_rdata;
    assign dbus.resp_rdata = mem.resp_rdata;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy    <= 1'b0;
            owner_d <= 1'b0;
            last_d  <= 1'b0;
        end else if (xfer) begin
            busy    <= 1'b1;
            owner_d <= grant_d;
            last_d  <= grant_d;
        end else if (mem.resp_valid) begin
            busy <= 1'b0;
        end
    end

    a_one_grant: assert property (@(posedge clk_in) disable iff (reset)
        !(grant_i && grant_d));

    // Memory must not answer a request this arbiter never passed on.
    a_resp_owned: assert property (@(posedge clk_in) disable iff (reset)
        mem.resp_valid |-> busy);

endmodule

/* verilog/delay_memory.sv */
module delay_memory #(
    parameter int MEM_ADDR_W = 10,
    parameter int MEM_DELAY  = 4
) (
    input  logic         clk_in,
    input  logic         reset,
    mem_bus_if.responder bus
);
    import soc_pkg::*;

    localparam int CNT_W = $clog2(MEM_DELAY + 1);

    uint_x                 mem_q [2**MEM_ADDR_W];
    logic                  busy;
    logic [CNT_W-1:0]      count;
    logic [MEM_ADDR_W-1:0] lat_idx;
    logic                  lat_wen;
    uint_x                 lat_wdata;
    logic                  xfer;
    logic                  done;

    assign bus.req_ready  = !busy;
    assign xfer           = bus.req_valid && bus.req_ready;
    assign done           = busy && (count == CNT_W'(1));  // Last cycle of the delay.
    assign bus.resp_valid = done;
    assign bus.resp_rdata = lat_wen ? '0 : mem_q[lat_idx];

    always_ff @(posedge clk_in) begin
        if (reset) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (xfer) begin
            busy  <= 1'b1;
            count <= CNT_W'(MEM_DELAY);
        end else if (done) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk_in) begin
        if (xfer) begin
            lat_idx   <= bus.req_addr[MEM_ADDR_W+1:2];   // Word address.
            lat_wen   <= bus.req_wen;
            lat_wdata <= bus.req_wdata;
        end
        if (done && lat_wen) begin
            mem_q[lat_idx] <= lat_wdata;
        end
    end

    // Answer lands exactly MEM_DELAY later with no new transfer in between.
    a_no_xfer_busy: assert property (@(posedge clk_in) disable iff (reset)
        xfer |-> ##MEM_DELAY (bus.resp_valid && !xfer));

endmodule

/* verilog/soc_top.sv */
module soc_top #(
    parameter int FMAX_MHz   = 27,
    parameter int MEM_ADDR_W = 10,
    parameter int MEM_DELAY  = 4
) (
    input  logic           clk_in,
    input  logic           reset,
    input  logic           i_req_valid,
    output logic           i_req_ready,
    input  soc_pkg::uint_x i_req_addr,
    output logic           i_resp_valid,
    output soc_pkg::uint_x i_resp_rdata,
    input  logic           d_req_valid,
    output logic           d_req_ready,
    input  soc_pkg::uint_x d_req_addr,
    input  logic           d_req_wen,
    input  soc_pkg::uint_x d_req_wdata,
    output logic           d_resp_valid,
    output soc_pkg::uint_x d_resp_rdata,
    output logic [5:0]     led,
    output logic           exit,
    output logic           timer_irq
);
    import soc_pkg::*;

    uint64 mtime;
    uint64 cycle;

    mem_bus_if i_bus ();
    mem_bus_if d_bus ();
    mem_bus_if dm_bus ();
    mem_bus_if mem_bus ();

    // Fetch side is read only.
    assign i_bus.req_valid = i_req_valid;
    assign i_bus.req_addr  = i_req_addr;
    assign i_bus.req_wen   = 1'b0;
    assign i_bus.req_wdata = '0;
    assign i_req_ready     = i_bus.req_ready;
    assign i_resp_valid    = i_bus.resp_valid;
    assign i_resp_rdata    = i_bus.resp_rdata;

    assign d_bus.req_valid = d_req_valid;
    assign d_bus.req_addr  = d_req_addr;
    assign d_bus.req_wen   = d_req_wen;
    assign d_bus.req_wdata = d_req_wdata;
    assign d_req_ready     = d_bus.req_ready;
    assign d_resp_valid    = d_bus.resp_valid;
    assign d_resp_rdata    = d_bus.resp_rdata;

    soc_timer #(.FMAX_MHz(FMAX_MHz)) u_timer (
        .clk_in(clk_in), .reset(reset), .mtime(mtime), .cycle(cycle)
    );

    mmio_cntr u_mmio (
        .clk_in(clk_in), .reset(reset), .core(d_bus), .mem(dm_bus),
        .mtime(mtime), .cycle(cycle), .led(led), .exit(exit), .timer_irq(timer_irq)
    );

    mem_bus_arbiter u_arb (
        .clk_in(clk_in), .reset(reset), .ibus(i_bus), .dbus(dm_bus), .mem(mem_bus)
    );

    delay_memory #(.MEM_ADDR_W(MEM_ADDR_W), .MEM_DELAY(MEM_DELAY)) u_mem (
        .clk_in(clk_in), .reset(reset), .bus(mem_bus)
    );

endmodule

/* dv/tb_soc_top.sv */
module tb_soc_top;
    import soc_pkg::*;

    localparam int FMAX_MHz    = 4;
    localparam int MEM_ADDR_W  = 10;
    localparam int MEM_DELAY   = 4;
    localparam int NUM_WORDS   = 8;
    localparam int NUM_ENTRIES = 3 * NUM_WORDS + 5;
    localparam int WATCHDOG    = NUM_ENTRIES * (MEM_DELAY + 20) + 200;
    localparam int PAIR_LIMIT  = 2 * (MEM_DELAY + 1) + 2;  // Two memory latencies plus handshake.

    typedef struct packed {
        logic  is_data;
        logic  wen;
        uint_x addr;
        uint_x wdata;
        uint_x exp;
    } entry_t;

    logic       clk_in = 1'b0;
    logic       reset;
    logic       i_req_valid;
    logic       i_req_ready;
    uint_x      i_req_addr;
    logic       i_resp_valid;
    uint_x      i_resp_rdata;
    logic       d_req_valid;
    logic       d_req_ready;
    uint_x      d_req_addr;
    logic       d_req_wen;
    uint_x      d_req_wdata;
    logic       d_resp_valid;
    uint_x      d_resp_rdata;
    logic [5:0] led;
    logic       exit;
    logic       timer_irq;

    entry_t stim [NUM_ENTRIES];
    string  stim_name [NUM_ENTRIES];
    int     n_entries;
    uint_x  model [NUM_WORDS];                           // Words written to memory.
    int     word_idx [NUM_WORDS];
    uint_x  lfsr;
    uint_x  gp_word;

    soc_top #(
        .FMAX_MHz(FMAX_MHz), .MEM_ADDR_W(MEM_ADDR_W), .MEM_DELAY(MEM_DELAY)
    ) i_dut (
        .clk_in(clk_in), .reset(reset),
        .i_req_valid(i_req_valid), .i_req_ready(i_req_ready), .i_req_addr(i_req_addr),
        .i_resp_valid(i_resp_valid), .i_resp_rdata(i_resp_rdata),
        .d_req_valid(d_req_valid), .d_req_ready(d_req_ready), .d_req_addr(d_req_addr),
        .d_req_wen(d_req_wen), .d_req_wdata(d_req_wdata),
        .d_resp_valid(d_resp_valid), .d_resp_rdata(d_resp_rdata),
        .led(led), .exit(exit), .timer_irq(timer_irq)
    );

    always #2 clk_in = ~clk_in;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic check_word(input string name, input uint_x exp, input uint_x act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR: %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_led(input string name, input logic [5:0] exp, input logic [5:0] act);
        if (act !== exp) begin
            fail_run($sformatf("ERROR: %s expected %h actual %h", name, exp, act));
        end
    endtask

    // Right-shift Galois form, taps of x^32+x^22+x^2+x+1.
    function automatic uint_x lfsr_next(input uint_x state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic next_random_word(output uint_x word);
        for (int b = 0; b < XLEN; b++) begin
            lfsr    = lfsr_next(lfsr);
            word[b] = lfsr[0];
        end
    endtask

    function automatic uint_x mem_addr(input int idx);
        bus_addr_u a;
        a              = '0;
        a.mem.word_idx = MEM_IDX_W'(idx);
        return a;
    endfunction

    function automatic uint_x mmio_addr(input mmio_reg_e r);
        bus_addr_u a;
        a              = '0;
        a.mmio.is_mmio = 1'b1;
        a.mmio.reg_idx = r;
        return a;
    endfunction

    task automatic add_entry(input string name, input logic is_data, input logic wen,
                             input uint_x addr, input uint_x wdata, input uint_x exp);
        stim_name[n_entries] = name;
        stim[n_entries]      = '{is_data, wen, addr, wdata, exp};
        n_entries++;
    endtask

    task automatic build_table();
        n_entries = 0;
        for (int k = 0; k < NUM_WORDS; k++) begin
            word_idx[k] = (k * 97 + 13) % (2 ** MEM_ADDR_W);
            next_random_word(model[k]);
            add_entry($sformatf("d_write_%0d", k), 1'b1, 1'b1, mem_addr(word_idx[k]),
                      model[k], '0);                   // Write answers carry zero.
        end
        for (int k = NUM_WORDS - 1; k >= 0; k--) begin
            add_entry($sformatf("d_read_%0d", k), 1'b1, 1'b0, mem_addr(word_idx[k]),
                      '0, model[k]);
        end
        for (int k = 0; k < NUM_WORDS; k++) begin
            add_entry($sformatf("i_read_%0d", k), 1'b0, 1'b0, mem_addr(word_idx[k]),
                      '0, model[k]);
        end
        next_random_word(gp_word);
        add_entry("mtimecmp_lo_reset", 1'b1, 1'b0, mmio_addr(MTIMECMP_LO), '0, '1);
        add_entry("mtimecmp_hi_reset", 1'b1, 1'b0, mmio_addr(MTIMECMP_HI), '0, '1);
        add_entry("gp_write", 1'b1, 1'b1, mmio_addr(GP), gp_word, '0);
        add_entry("gp_read", 1'b1, 1'b0, mmio_addr(GP), '0, gp_word);
        add_entry("exit_reset", 1'b1, 1'b0, mmio_addr(EXIT), '0, '0);
    endtask

    task automatic data_access(input logic wen, input uint_x addr, input uint_x wdata,
                               output uint_x rdata, output int cycles);
        cycles = 0;
        d_req_valid <= 1'b1;
        d_req_wen   <= wen;
        d_req_addr  <= addr;
        d_req_wdata <= wdata;
        do begin
            @(posedge clk_in);
            cycles++;
        end while (!d_req_ready);
        d_req_valid <= 1'b0;
        do begin
            @(posedge clk_in);
            cycles++;
        end while (!d_resp_valid);
        rdata = d_resp_rdata;
    endtask

    task automatic instr_read(input uint_x addr, output uint_x rdata, output int cycles);
        cycles = 0;
        i_req_valid <= 1'b1;
        i_req_addr  <= addr;
        do begin
            @(posedge clk_in);
            cycles++;
        end while (!i_req_ready);
        i_req_valid <= 1'b0;
        do begin
            @(posedge clk_in);
            cycles++;
        end while (!i_resp_valid);
        rdata = i_resp_rdata;
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk_in);
        fail_run($sformatf("The test timed out after %0d cycles.", WATCHDOG));
    end

    initial begin
        uint_x rdata;
        uint_x rd_i;
        uint_x rd_d;
        uint_x c0;
        uint_x c1;
        uint_x m0;
        uint_x m1;
        uint_x mt;
        int    cycles;
        int    cyc_i;
        int    cyc_d;
        reset       = 1'b1;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        d_req_valid = 1'b0;
        d_req_addr  = '0;
        d_req_wen   = 1'b0;
        d_req_wdata = '0;
        lfsr        = 32'd77;
        build_table();
        repeat (8) @(posedge clk_in);
        reset <= 1'b0;
        @(posedge clk_in);

        check_led("reset_led", 6'h3f, led);
        check_bit("reset_exit", 1'b0, exit);
        check_bit("reset_irq", 1'b0, timer_irq);
        check_bit("reset_i_resp", 1'b0, i_resp_valid);
        check_bit("reset_d_resp", 1'b0, d_resp_valid);

        for (int e = 0; e < n_entries; e++) begin
            if (stim[e].is_data) begin
                data_access(stim[e].wen, stim[e].addr, stim[e].wdata, rdata, cycles);
            end else begin
                instr_read(stim[e].addr, rdata, cycles);
            end
            check_word(stim_name[e], stim[e].exp, rdata);
        end
        check_led("gp_led", ~gp_word[5:0], led);
        check_bit("irq_cmp_reset", 1'b0, timer_irq);

        // Same-cycle requests, once per round-robin winner.
        for (int p = 0; p < 2; p++) begin
            if (p == 1) begin
                data_access(1'b0, mem_addr(word_idx[2]), '0, rdata, cycles);
                check_word("lone_d_read", model[2], rdata);  // Data wins last so fetch gets the tie.
            end
            fork
                instr_read(mem_addr(word_idx[p]), rd_i, cyc_i);
                data_access(1'b0, mem_addr(word_idx[NUM_WORDS-1-p]), '0, rd_d, cyc_d);
            join
            check_word($sformatf("pair_%0d_i_data", p), model[p], rd_i);
            check_word($sformatf("pair_%0d_d_data", p), model[NUM_WORDS-1-p], rd_d);
            check_bit($sformatf("pair_%0d_i_in_time", p), 1'b1, cyc_i <= PAIR_LIMIT);
            check_bit($sformatf("pair_%0d_d_in_time", p), 1'b1, cyc_d <= PAIR_LIMIT);
            check_bit($sformatf("pair_%0d_d_first", p), p == 0, cyc_d < cyc_i);
        end

        data_access(1'b0, mmio_addr(CYCLE_LO), '0, c0, cycles);
        data_access(1'b0, mmio_addr(MTIME_LO), '0, m0, cycles);
        repeat (40) @(posedge clk_in);
        data_access(1'b0, mmio_addr(CYCLE_LO), '0, c1, cycles);
        data_access(1'b0, mmio_addr(MTIME_LO), '0, m1, cycles);
        check_bit("cycle_monotonic", 1'b1, c1 >= c0);
        check_bit("mtime_monotonic", 1'b1, m1 >= m0);
        check_bit("cycle_faster", 1'b1, (c1 - c0) > (m1 - m0));

        data_access(1'b0, mmio_addr(MTIME_LO), '0, mt, cycles);
        data_access(1'b1, mmio_addr(MTIMECMP_HI), '0, rdata, cycles);
        data_access(1'b1, mmio_addr(MTIMECMP_LO), mt + 32'd4, rdata, cycles);
        check_bit("irq_before_match", 1'b0, timer_irq);
        cycles = 0;
        while (!timer_irq) begin
            if (cycles > 8 * FMAX_MHz) begin
                fail_run("timer_irq did not rise after mtimecmp was set near mtime.");
            end
            @(posedge clk_in);
            cycles++;
        end

        check_bit("exit_before_write", 1'b0, exit);
        data_access(1'b1, mmio_addr(EXIT), 32'd1, rdata, cycles);
        check_bit("exit_set", 1'b1, exit);
        repeat (10) @(posedge clk_in);
        check_bit("exit_sticky", 1'b1, exit);
        data_access(1'b0, mmio_addr(EXIT), '0, rdata, cycles);
        check_word("exit_read", 32'd1, rdata);

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* src.f */
verilog/soc_pkg.sv
verilog/mem_bus_if.sv
verilog/soc_timer.sv
verilog/mmio_cntr.sv
verilog/mem_bus_arbiter.sv
verilog/delay_memory.sv
verilog/soc_top.sv
dv/tb_soc_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log
FAIL_MSG='*** TEST FAILED ***'
PASS_MSG='*** TEST PASSED ***'

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_soc_top --Mdir "$BUILD_DIR" -o sim_tb

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qF "$FAIL_MSG" "$LOG"; then
    echo "Simulation reported a failure."
    exit 1
fi
if ! grep -qF "$PASS_MSG" "$LOG"; then
    echo "Simulation ended without a result."
    exit 1
fi
echo "Simulation finished cleanly."
